// File: rtl/fh_epath_params.svh
`ifndef FH_EPATH_PARAMS_SVH
`define FH_EPATH_PARAMS_SVH

// --------------------------------------------------
// e-path word and fifo geometry
// --------------------------------------------------

// host word, 2-bit kind plus 16-bit body
`define FH_WORD_W 18

// fifo address bits and depth
`define FH_ADDR_W 4
`define FH_DEPTH (1 << `FH_ADDR_W)

// fill thresholds
`define FH_ALMOST_FULL (`FH_DEPTH - 2)
`define FH_PROG_FULL 8

// saturating drop counter width
`define FH_ERR_W 8

`endif

// File: rtl/fh_word_pkg.sv
`include "fh_epath_params.svh"

package fh_word_pkg;

  // word kinds in the top two bits
  typedef enum logic [1:0] {
    FH_KIND_DATA   = 2'b00,
    FH_KIND_HEADER = 2'b01,
    FH_KIND_IDLE   = 2'b10,
    FH_KIND_RSVD   = 2'b11
  } fh_kind_e;

  // payload view
  typedef struct packed {
    fh_kind_e                kind;
    logic [`FH_WORD_W-3:0]   payload;
  } fh_data_view_t;

  // header view, channel in the high byte
  typedef struct packed {
    fh_kind_e    kind;
    logic [7:0]  channel;
    logic [7:0]  count;
  } fh_hdr_view_t;

  // same 18 bits, read either way
  typedef union packed {
    fh_data_view_t data;
    fh_hdr_view_t  hdr;
  } fh_word_u;

endpackage

// File: rtl/fh_stream_pkg.sv
package fh_stream_pkg;

  // --------------------------------------------------
  // ctrl to unpacker command
  // --------------------------------------------------
  typedef struct packed {
    // two bytes, high first, or only the low byte
    logic        two;
    logic [15:0] data;
    // channel byte of a frame
    logic        first;
    // byte value comes from the crc module
    logic        use_crc;
    // closing byte of a frame
    logic        last;
  } fh_byte_cmd_t;

  // --------------------------------------------------
  // output byte stream
  // --------------------------------------------------
  typedef struct packed {
    logic [7:0] data;
    logic       first;
    logic       last;
  } fh_out_byte_t;

endpackage

// File: rtl/fh_epath_fifo.sv
`timescale 1ns/1ps
`include "fh_epath_params.svh"

module fh_epath_fifo
  import fh_word_pkg::*;
(
  input  logic     c_clk,
  input  logic     c_rst,
  input  fh_word_u din,
  input  logic     wr_en,
  input  logic     rd_en,
  output fh_word_u dout,
  output logic     full,
  output logic     almost_full,
  output logic     prog_full,
  output logic     empty
);

  // flag levels at count width
  localparam logic [`FH_ADDR_W:0] FULL_LVL   = `FH_DEPTH - 1;
  localparam logic [`FH_ADDR_W:0] ALMOST_LVL = `FH_ALMOST_FULL;
  localparam logic [`FH_ADDR_W:0] PROG_LVL   = `FH_PROG_FULL;

  fh_word_u mem [`FH_DEPTH];

  logic [`FH_ADDR_W-1:0] wr_ptr;
  logic [`FH_ADDR_W-1:0] rd_ptr;
  // one bit wider than the pointers
  logic [`FH_ADDR_W:0]   count;

  logic wr_ok;
  logic rd_ok;

  // full blocks writes, empty blocks reads
  assign wr_ok = wr_en && !full;
  assign rd_ok = rd_en && !empty;

  // --------------------------------------------------
  // flags straight from the fill count
  // --------------------------------------------------
  // one slot stays unused, full at depth-1
  assign full        = (count == FULL_LVL);
  assign almost_full = (count >= ALMOST_LVL);
  assign prog_full   = (count >= PROG_LVL);
  assign empty       = (count == '0);

  // storage, a write while full leaves it as is
  always_ff @(posedge c_clk)
  begin
    if (wr_ok)
      mem[wr_ptr] <= din;
  end

  // read word shows up the cycle after rd_en
  always_ff @(posedge c_clk)
  begin
    if (rd_ok)
      dout <= mem[rd_ptr];
  end

  // --------------------------------------------------
  // pointers and fill count
  // --------------------------------------------------
  always_ff @(posedge c_clk or posedge c_rst)
  begin
    if (c_rst)
    begin
      wr_ptr <= '0;
      rd_ptr <= '0;
      count  <= '0;
    end
    else
    begin
      // pointers wrap at depth
      if (wr_ok)
        wr_ptr <= wr_ptr + 1'b1;
      if (rd_ok)
        rd_ptr <= rd_ptr + 1'b1;
      // simultaneous read and write keeps the count
      case ({wr_ok, rd_ok})
        2'b10:   count <= count + 1'b1;
        2'b01:   count <= count - 1'b1;
        default: count <= count;
      endcase
    end
  end

endmodule

// File: rtl/fh_epath_ctrl.sv
`timescale 1ns/1ps
`include "fh_epath_params.svh"

module fh_epath_ctrl
  import fh_word_pkg::*;
  import fh_stream_pkg::*;
(
  input  logic                 c_clk,
  input  logic                 c_rst,
  input  logic                 drain_en,
  input  logic                 fifo_empty,
  input  fh_word_u             fifo_word,
  input  logic                 busy,
  input  logic [7:0]           crc_value,
  output logic                 rd_en,
  output logic                 cmd_valid,
  output fh_byte_cmd_t         cmd,
  output logic [`FH_ERR_W-1:0] err_count
);

  // outside a frame, inside a frame, crc byte owed
  typedef enum logic [1:0] {
    ST_IDLE,
    ST_DATA,
    ST_CRC
  } state_e;

  state_e     state_q;
  state_e     state_d;
  logic [7:0] remain_q;
  logic [7:0] remain_d;
  logic       rd_pend;
  logic       err_inc;
  fh_kind_e   kind;

  // kind bits sit in the same place in both views
  assign kind = fifo_word.data.kind;

  // --------------------------------------------------
  // fifo reads
  // --------------------------------------------------
  // one read in flight, none while the crc byte is owed
  // a processed word never meets a busy unpacker this way
  assign rd_en = drain_en && !fifo_empty && !rd_pend && (state_q != ST_CRC);

  // --------------------------------------------------
  // word decode and command issue
  // --------------------------------------------------
  always_comb
  begin
    state_d   = state_q;
    remain_d  = remain_q;
    err_inc   = 1'b0;
    cmd_valid = 1'b0;
    cmd       = '0;
    case (state_q)
      ST_IDLE:
      begin
        if (rd_pend)
        begin
          case (kind)
            FH_KIND_HEADER:
            begin
              // channel byte opens the frame
              cmd_valid = 1'b1;
              cmd.first = 1'b1;
              cmd.data  = {8'h00, fifo_word.hdr.channel};
              remain_d  = fifo_word.hdr.count;
              // empty frame goes straight to its crc
              state_d   = (fifo_word.hdr.count == 8'd0) ? ST_CRC : ST_DATA;
            end
            FH_KIND_IDLE: ;
            // stray data or reserved word
            default: err_inc = 1'b1;
          endcase
        end
      end
      ST_DATA:
      begin
        if (rd_pend)
        begin
          case (kind)
            FH_KIND_DATA:
            begin
              // payload, high byte first
              cmd_valid = 1'b1;
              cmd.two   = 1'b1;
              cmd.data  = fifo_word.data.payload;
              remain_d  = remain_q - 8'd1;
              if (remain_q == 8'd1)
                state_d = ST_CRC;
            end
            FH_KIND_IDLE: ;
            // header or reserved inside a frame is dropped
            default: err_inc = 1'b1;
          endcase
        end
      end
      default:
      begin
        // wait out the second payload byte
        if (!busy)
        begin
          cmd_valid   = 1'b1;
          cmd.use_crc = 1'b1;
          cmd.last    = 1'b1;
          state_d     = ST_IDLE;
        end
      end
    endcase
  end

  // --------------------------------------------------
  // state, read tracking, drop counter
  // --------------------------------------------------
  always_ff @(posedge c_clk or posedge c_rst)
  begin
    if (c_rst)
    begin
      state_q   <= ST_IDLE;
      remain_q  <= '0;
      rd_pend   <= 1'b0;
      err_count <= '0;
    end
    else
    begin
      state_q  <= state_d;
      remain_q <= remain_d;
      rd_pend  <= rd_en;
      // saturates at all ones
      if (err_inc && (err_count != '1))
        err_count <= err_count + 1'b1;
    end
  end

endmodule

// File: rtl/fh_byte_unpacker.sv
`timescale 1ns/1ps

module fh_byte_unpacker
  import fh_stream_pkg::*;
(
  input  logic         c_clk,
  input  logic         c_rst,
  input  logic         cmd_valid,
  input  fh_byte_cmd_t cmd,
  input  logic [7:0]   crc_value,
  output logic         busy,
  output logic         out_valid,
  output fh_out_byte_t out_byte
);

  // second byte still owed
  logic       pending;
  // current byte and its flags
  logic [7:0] byte_q;
  logic       first_q;
  logic       last_q;
  logic       sel_crc;
  // held low byte and its last flag
  logic [7:0] low_q;
  logic       low_last;

  assign busy = pending;

  // crc byte taken live, it already covers the byte before it
  assign out_byte.data  = sel_crc ? crc_value : byte_q;
  assign out_byte.first = first_q;
  assign out_byte.last  = last_q;

  // --------------------------------------------------
  // byte payload
  // --------------------------------------------------
  always_ff @(posedge c_clk)
  begin
    if (cmd_valid)
    begin
      byte_q   <= cmd.two ? cmd.data[15:8] : cmd.data[7:0];
      first_q  <= cmd.first;
      // two-byte command carries last on its low byte
      last_q   <= cmd.two ? 1'b0 : cmd.last;
      sel_crc  <= cmd.use_crc;
      low_q    <= cmd.data[7:0];
      low_last <= cmd.last;
    end
    else if (pending)
    begin
      byte_q  <= low_q;
      first_q <= 1'b0;
      last_q  <= low_last;
      sel_crc <= 1'b0;
    end
  end

  // --------------------------------------------------
  // strobe and busy
  // --------------------------------------------------
  always_ff @(posedge c_clk or posedge c_rst)
  begin
    if (c_rst)
    begin
      out_valid <= 1'b0;
      pending   <= 1'b0;
    end
    else
    begin
      out_valid <= cmd_valid || pending;
      // ctrl never sends while pending
      pending   <= cmd_valid && cmd.two;
    end
  end

endmodule

// File: rtl/fh_crc8.sv
`timescale 1ns/1ps

module fh_crc8
  import fh_stream_pkg::*;
(
  input  logic         c_clk,
  input  logic         c_rst,
  input  logic         out_valid,
  input  fh_out_byte_t out_byte,
  output logic [7:0]   crc_value
);

  // poly 0x07, msb first, no final xor
  function automatic logic [7:0] crc8_fold(input logic [7:0] crc, input logic [7:0] data);
    logic [7:0] c;
    c = crc ^ data;
    for (int i = 0; i < 8; i++)
    begin
      if (c[7])
        c = {c[6:0], 1'b0} ^ 8'h07;
      else
        c = {c[6:0], 1'b0};
    end
    return c;
  endfunction

  // --------------------------------------------------
  // running crc over channel and payload bytes
  // --------------------------------------------------
  always_ff @(posedge c_clk or posedge c_rst)
  begin
    if (c_rst)
      crc_value <= 8'h00;
    // the crc byte itself is left out
    else if (out_valid && !out_byte.last)
      // channel byte restarts from zero
      crc_value <= crc8_fold(out_byte.first ? 8'h00 : crc_value, out_byte.data);
  end

endmodule

// File: rtl/fh_epath_top.sv
`timescale 1ns/1ps
`include "fh_epath_params.svh"

module fh_epath_top
  import fh_word_pkg::*;
  import fh_stream_pkg::*;
(
  input  logic                 c_clk,
  input  logic                 c_rst,
  input  fh_word_u             din,
  input  logic                 wr_en,
  input  logic                 drain_en,
  output logic                 full,
  output logic                 almost_full,
  output logic                 prog_full,
  output logic                 empty,
  output logic                 out_valid,
  output fh_out_byte_t         out_byte,
  output logic [`FH_ERR_W-1:0] err_count
);

  // fifo to ctrl
  fh_word_u     fifo_word;
  logic         rd_en;
  // ctrl to unpacker
  logic         cmd_valid;
  fh_byte_cmd_t cmd;
  logic         busy;
  // crc back to ctrl and unpacker
  logic [7:0]   crc_value;

  // --------------------------------------------------
  // word buffer
  // --------------------------------------------------
  fh_epath_fifo i_fifo (
    .c_clk       (c_clk),
    .c_rst       (c_rst),
    .din         (din),
    .wr_en       (wr_en),
    .rd_en       (rd_en),
    .dout        (fifo_word),
    .full        (full),
    .almost_full (almost_full),
    .prog_full   (prog_full),
    .empty       (empty)
  );

  // frame parser
  fh_epath_ctrl i_ctrl (
    .c_clk      (c_clk),
    .c_rst      (c_rst),
    .drain_en   (drain_en),
    .fifo_empty (empty),
    .fifo_word  (fifo_word),
    .busy       (busy),
    .crc_value  (crc_value),
    .rd_en      (rd_en),
    .cmd_valid  (cmd_valid),
    .cmd        (cmd),
    .err_count  (err_count)
  );

  // --------------------------------------------------
  // byte stream and its crc
  // --------------------------------------------------
  fh_byte_unpacker i_unpacker (
    .c_clk     (c_clk),
    .c_rst     (c_rst),
    .cmd_valid (cmd_valid),
    .cmd       (cmd),
    .crc_value (crc_value),
    .busy      (busy),
    .out_valid (out_valid),
    .out_byte  (out_byte)
  );

  fh_crc8 i_crc8 (
    .c_clk     (c_clk),
    .c_rst     (c_rst),
    .out_valid (out_valid),
    .out_byte  (out_byte),
    .crc_value (crc_value)
  );

endmodule

// File: testbench/fh_epath_tb.sv
`timescale 1ns/1ps
`include "fh_epath_params.svh"

module fh_epath_tb
  import fh_word_pkg::*;
  import fh_stream_pkg::*;
();

  // cycles any single wait may take
  localparam int TIMEOUT_CYC = 400;

  logic                 c_clk;
  logic                 c_rst;
  fh_word_u             din;
  logic                 wr_en;
  logic                 drain_en;
  logic                 full;
  logic                 almost_full;
  logic                 prog_full;
  logic                 empty;
  logic                 out_valid;
  fh_out_byte_t         out_byte;
  logic [`FH_ERR_W-1:0] err_count;

  // bytes still owed by the DUT in order
  fh_out_byte_t exp_q[$];
  fh_out_byte_t got_exp;
  // running crc of the frame being read from the file
  logic [7:0]   frame_crc;

  fh_epath_top i_dut (
    .c_clk       (c_clk),
    .c_rst       (c_rst),
    .din         (din),
    .wr_en       (wr_en),
    .drain_en    (drain_en),
    .full        (full),
    .almost_full (almost_full),
    .prog_full   (prog_full),
    .empty       (empty),
    .out_valid   (out_valid),
    .out_byte    (out_byte),
    .err_count   (err_count)
  );

  // 4 ns period
  initial
  begin
    c_clk = 1'b0;
    forever #2 c_clk = ~c_clk;
  end

  // --------------------------------------------------
  // error reporting and checks
  // --------------------------------------------------
  task automatic stop_run(input string what);
    $display("%s", what);
    $display("Simulation FAILED");
    $fatal(1, "run stopped at first error");
  endtask

  task automatic check_value(input string name, input int got, input int want);
    assert (got == want)
    else
      stop_run($sformatf("[FAIL] %t %s got 0x%0h expected 0x%0h", $time, name, got, want));
  endtask

  task automatic check_flag(input string name, input int want);
    logic got;
    case (name)
      "full":        got = full;
      "almost_full": got = almost_full;
      "prog_full":   got = prog_full;
      "empty":       got = empty;
      default:       stop_run($sformatf("unknown flag name %s in the tests file", name));
    endcase
    check_value(name, int'(got), want);
  endtask

  // poly 0x07 fed one bit at a time with msb first
  function automatic logic [7:0] crc8_next(input logic [7:0] crc, input logic [7:0] b);
    logic [7:0] r;
    logic       fb;
    r = crc;
    for (int i = 7; i >= 0; i--)
    begin
      fb = r[7] ^ b[i];
      r  = {r[6:0], 1'b0};
      if (fb)
        r = r ^ 8'h07;
    end
    return r;
  endfunction

  // --------------------------------------------------
  // stimulus helpers
  // --------------------------------------------------
  // one word per rising edge
  task automatic write_words(input logic [17:0] w, input int reps);
    for (int i = 0; i < reps; i++)
    begin
      @(posedge c_clk);
      din   <= w;
      wr_en <= 1'b1;
    end
  endtask

  // lets the last write land, then drops wr_en
  task automatic end_writes();
    @(posedge c_clk);
    wr_en <= 1'b0;
  endtask

  // queue a byte and check the file crc on the closing byte
  task automatic expect_byte(input logic [7:0] b, input logic f, input logic l);
    fh_out_byte_t e;
    e.data  = b;
    e.first = f;
    e.last  = l;
    if (f)
      frame_crc = crc8_next(8'h00, b);
    else if (l)
      check_value("crc byte in tests file", int'(b), int'(frame_crc));
    else
      frame_crc = crc8_next(frame_crc, b);
    exp_q.push_back(e);
  endtask

  // all expected bytes out and nothing left in the fifo
  task automatic wait_drained();
    int cyc;
    cyc = 0;
    while ((exp_q.size() != 0 || !empty) && cyc < TIMEOUT_CYC)
    begin
      @(negedge c_clk);
      cyc++;
    end
    assert (exp_q.size() == 0 && empty)
    else
      stop_run($sformatf("timeout waiting for the output and fifo to drain, %0d bytes owed",
                         exp_q.size()));
  endtask

  // drops are counted a few cycles after the write
  task automatic wait_err_count(input int want);
    int cyc;
    cyc = 0;
    while (int'(err_count) != want && cyc < TIMEOUT_CYC)
    begin
      @(negedge c_clk);
      cyc++;
    end
    check_value("err_count", int'(err_count), want);
  endtask

  // --------------------------------------------------
  // tests file interpreter
  // --------------------------------------------------
  task automatic run_tests_file();
    int          fd;
    int          n;
    string       line;
    string       op;
    string       name;
    logic [17:0] word;
    logic [7:0]  bval;
    int          a;
    int          c;
    fd = $fopen("testbench/fh_epath_tests.txt", "r");
    assert (fd != 0)
    else
      stop_run("could not open testbench/fh_epath_tests.txt");
    while (!$feof(fd))
    begin
      n = $fgets(line, fd);
      if (n == 0)
        continue;
      // blank and comment lines
      if ($sscanf(line, "%s", op) != 1)
        continue;
      if (op.getc(0) == "#")
        continue;
      case (op)
        "W":
        begin
          n = $sscanf(line, "%s %h %d", op, word, a);
          write_words(word, a);
        end
        "D":
        begin
          n = $sscanf(line, "%s %d", op, a);
          end_writes();
          drain_en <= a[0];
        end
        "F":
        begin
          n = $sscanf(line, "%s %s %d", op, name, a);
          end_writes();
          // flags settle after the edge
          @(negedge c_clk);
          check_flag(name, a);
        end
        "E":
        begin
          n = $sscanf(line, "%s %h %d %d", op, bval, a, c);
          expect_byte(bval, a[0], c[0]);
        end
        "C":
        begin
          n = $sscanf(line, "%s %d", op, a);
          end_writes();
          wait_err_count(a);
        end
        "S":
        begin
          end_writes();
          wait_drained();
        end
        default: stop_run($sformatf("unknown command %s in the tests file", op));
      endcase
    end
    $fclose(fd);
  endtask

  // --------------------------------------------------
  // output monitor
  // --------------------------------------------------
  // bytes compared in file order
  always @(negedge c_clk)
  begin
    if (!c_rst && out_valid)
    begin
      assert (exp_q.size() != 0)
      else
        stop_run($sformatf("output byte 0x%0h came out with no byte expected", out_byte.data));
      got_exp = exp_q.pop_front();
      check_value("out_byte.data", int'(out_byte.data), int'(got_exp.data));
      check_value("out_byte.first", int'(out_byte.first), int'(got_exp.first));
      check_value("out_byte.last", int'(out_byte.last), int'(got_exp.last));
    end
  end

  // --------------------------------------------------
  // fifo flag levels
  // --------------------------------------------------
  // full sits above almost_full above prog_full
  always @(negedge c_clk)
  begin
    if (!c_rst)
    begin
      if (full)
        check_value("almost_full", int'(almost_full), 1);
      if (almost_full)
        check_value("prog_full", int'(prog_full), 1);
      // no threshold reached while empty
      if (empty)
        check_value("prog_full", int'(prog_full), 0);
    end
  end

  // main sequence
  initial
  begin
    $timeformat(-9, 1, " ns", 0);
    c_rst     <= 1'b1;
    din       <= '0;
    wr_en     <= 1'b0;
    drain_en  <= 1'b0;
    frame_crc  = 8'h00;
    // reset for two cycles
    repeat (2) @(posedge c_clk);
    c_rst <= 1'b0;
    run_tests_file();
    end_writes();
    wait_drained();
    $display("Simulation PASSED");
    $finish;
  end

endmodule

// File: tb.f
+incdir+rtl
rtl/fh_word_pkg.sv
rtl/fh_stream_pkg.sv
rtl/fh_epath_fifo.sv
rtl/fh_epath_ctrl.sv
rtl/fh_byte_unpacker.sv
rtl/fh_crc8.sv
rtl/fh_epath_top.sv
testbench/fh_epath_tb.sv

// File: run_sim.sh
#!/usr/bin/env bash
# build and run the e-path testbench with verilator

cd "$(dirname "$0")" || exit 1

log=sim.log
rm -f "$log"

verilator --binary --timing --assert -Wno-fatal \
  --top-module fh_epath_tb -Mdir obj_dir -f tb.f
if [ $? -ne 0 ]; then
  echo "verilator build failed"
  exit 1
fi

./obj_dir/Vfh_epath_tb > "$log" 2>&1
run_status=$?
cat "$log"

# the log decides the result
if grep -q "Simulation FAILED" "$log"; then
  echo "result: fail"
  exit 1
fi

# no verdict in the log but the run itself broke
if [ $run_status -ne 0 ]; then
  echo "simulation exited with status $run_status"
  exit 1
fi

echo "result: pass"
exit 0

// File: testbench/fh_epath_tests.txt
# W word(hex, kind in bits 17:16) repeat | D drain_en | F flag value
# E byte(hex) first last | C err_count | S wait for output and fifo to drain
# reset state
F empty 1
C 0
# header count 2 and two data words
E 01 1 0
E 12 0 0
E 34 0 0
E ab 0 0
E cd 0 0
E 81 0 1
D 1
W 10102 1
W 01234 1
W 0abcd 1
S
# idles before and inside a frame, then a count-zero header
E 02 1 0
E 00 0 0
E ff 0 0
E 25 0 1
E 03 1 0
E 09 0 1
W 20000 2
W 10201 1
W 20000 1
W 000ff 1
W 10300 1
S
C 0
# stray data and reserved, then header and reserved inside a frame
E 04 1 0
E 55 0 0
E 55 0 0
E 4a 0 1
W 01111 1
W 30000 1
W 10401 1
W 1aa03 1
W 3ffff 1
W 05555 1
S
C 4
# fill with drain off, one write too many, then drain
E 05 1 0
E 01 0 0
E 02 0 0
E 03 0 0
E 04 0 0
E 0e 0 1
D 0
W 10502 1
W 00102 1
W 20000 6
F prog_full 1
F almost_full 0
W 20000 6
F almost_full 1
F full 0
W 00304 1
F full 1
F empty 0
W 0beef 1
F full 1
D 1
S
F empty 1
C 4
# back-to-back frames, drain toggled mid-frame
E 06 1 0
E 80 0 0
E 01 0 0
E cc 0 1
E 07 1 0
E 00 0 0
E a5 0 0
E 5a 0 0
E 00 0 0
E 2f 0 1
W 10601 1
W 08001 1
W 10702 1
D 0
W 000a5 1
W 05a00 1
D 1
S
C 4
